//--- lookahead_route.f
+incdir+rtl
rtl/mesh_geometry_pkg.sv
rtl/route_pkg.sv
rtl/next_router_predictor.sv
rtl/xy_port_select.sv
rtl/lookahead_route_top.sv
verification/lookahead_route_chk.sv
verification/lookahead_route_tb.sv

//--- rtl/lookahead_route_top.sv
`timescale 1ns/100ps
`default_nettype none

module lookahead_route_top #(
    parameter mesh_geometry_pkg::coord_x_t ROUTER_X = '0, // this router
    parameter mesh_geometry_pkg::coord_y_t ROUTER_Y = '0
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  route_pkg::route_req_t req,
    input  logic                  req_valid,
    output logic                  req_ready,

    output route_pkg::route_rsp_t rsp,
    output logic                  rsp_valid,
    input  logic                  rsp_ready
);

    import route_pkg::*;

    predict_t mid;          // stage 1 result
    logic     mid_valid;
    logic     mid_ready;

    // decode and next router address
    next_router_predictor #(
        .ROUTER_X  (ROUTER_X),
        .ROUTER_Y  (ROUTER_Y)
    ) predict_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .mid       (mid),
        .mid_valid (mid_valid),
        .mid_ready (mid_ready)
    );

    // xy routing as seen from the next router
    xy_port_select select_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .mid       (mid),
        .mid_valid (mid_valid),
        .mid_ready (mid_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

endmodule

`default_nettype wire

//--- rtl/lookahead_settings.svh
`ifndef LOOKAHEAD_SETTINGS_SVH
`define LOOKAHEAD_SETTINGS_SVH

// mesh size, routers along each axis
`define LKR_NX 4
`define LKR_NY 4

// coordinate widths
`define LKR_XW 2 // clog2 of LKR_NX
`define LKR_YW 2 // clog2 of LKR_NY

`define LKR_PORTS 5 // local plus four neighbours

// encoded port is x, y and a two bit move class
`define LKR_DSTW 4

`endif

//--- rtl/mesh_geometry_pkg.sv
`default_nettype none

`include "lookahead_settings.svh"

package mesh_geometry_pkg;

    typedef logic [`LKR_XW-1:0] coord_x_t;
    typedef logic [`LKR_YW-1:0] coord_y_t;

    // edge routers, no wrap past these
    localparam coord_x_t LAST_X = coord_x_t'(`LKR_NX - 1);
    localparam coord_y_t LAST_Y = coord_y_t'(`LKR_NY - 1);

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } router_addr_t;

    // north is y-1, south is y+1
    typedef enum logic [$clog2(`LKR_PORTS)-1:0] {
        PORT_LOCAL = 0,
        PORT_EAST  = 1,
        PORT_NORTH = 2,
        PORT_WEST  = 3,
        PORT_SOUTH = 4
    } port_e;

endpackage

`default_nettype wire

//--- rtl/next_router_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module next_router_predictor #(
    parameter mesh_geometry_pkg::coord_x_t ROUTER_X = '0,
    parameter mesh_geometry_pkg::coord_y_t ROUTER_Y = '0
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  route_pkg::route_req_t req,
    input  logic                  req_valid,
    output logic                  req_ready,

    output route_pkg::predict_t   mid,
    output logic                  mid_valid,
    input  logic                  mid_ready
);

    import mesh_geometry_pkg::*;
    import route_pkg::*;

    localparam router_addr_t HERE = '{x: ROUTER_X, y: ROUTER_Y};

    port_e        cur_port;     // decoded current port
    router_addr_t next_addr;
    logic         take;         // request accepted this cycle

    predict_t     mid_q;
    logic         mid_valid_q;

    // decode the encoded port of this router
    always_comb begin
        case (req.cur_port.move)
            MOVE_LOCAL: begin
                cur_port = PORT_LOCAL;
            end
            MOVE_Y: begin
                cur_port = req.cur_port.y ? PORT_NORTH : PORT_SOUTH;
            end
            default: begin
                // x-move, and the illegal 11 is read the same way
                cur_port = req.cur_port.x ? PORT_EAST : PORT_WEST;
            end
        endcase
    end

    // one hop from this router, mesh edges do not wrap
    always_comb begin
        next_addr = HERE;
        case (cur_port)
            PORT_EAST: begin
                if (HERE.x != LAST_X)
                    next_addr.x = HERE.x + 1'b1;
            end
            PORT_WEST: begin
                if (HERE.x != '0)
                    next_addr.x = HERE.x - 1'b1;
            end
            PORT_NORTH: begin
                if (HERE.y != '0)
                    next_addr.y = HERE.y - 1'b1; // north is y-1
            end
            PORT_SOUTH: begin
                if (HERE.y != LAST_Y)
                    next_addr.y = HERE.y + 1'b1;
            end
            default: begin
                next_addr = HERE; // local, stays here
            end
        endcase
    end

    // one entry, free when empty or draining this cycle
    assign req_ready = !mid_valid_q || mid_ready;
    assign take      = req_valid && req_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid_valid_q <= 1'b0;
        end else if (req_ready) begin
            mid_valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mid_q.dest      <= req.dest;
            mid_q.next_addr <= next_addr;
            mid_q.cur_port  <= req.cur_port;
        end
    end

    assign mid       = mid_q;
    assign mid_valid = mid_valid_q;

endmodule

`default_nettype wire

//--- rtl/route_pkg.sv
`default_nettype none

`include "lookahead_settings.svh"

package route_pkg;

    // move class, 11 never comes out of xy routing
    typedef enum logic [`LKR_DSTW-3:0] {
        MOVE_LOCAL = 2'b00,
        MOVE_Y     = 2'b01,
        MOVE_X     = 2'b10,
        MOVE_XY    = 2'b11
    } move_e;

    typedef struct packed {
        logic  x;    // 1 east, 0 west
        logic  y;    // 1 north, 0 south
        move_e move;
    } dstport_enc_t;

    typedef struct packed {
        mesh_geometry_pkg::router_addr_t dest;
        dstport_enc_t                    cur_port;  // port chosen here
    } route_req_t;

    // stage 1 to stage 2
    typedef struct packed {
        mesh_geometry_pkg::router_addr_t dest;
        mesh_geometry_pkg::router_addr_t next_addr;
        dstport_enc_t                    cur_port;
    } predict_t;

    typedef struct packed {
        mesh_geometry_pkg::router_addr_t dest;
        mesh_geometry_pkg::router_addr_t next_addr;
        dstport_enc_t                    lk_port;   // port at the next router
    } route_rsp_t;

endpackage

`default_nettype wire

//--- rtl/xy_port_select.sv
`timescale 1ns/100ps
`default_nettype none

module xy_port_select (
    input  logic                  clk,
    input  logic                  arst_n,

    input  route_pkg::predict_t   mid,
    input  logic                  mid_valid,
    output logic                  mid_ready,

    output route_pkg::route_rsp_t rsp,
    output logic                  rsp_valid,
    input  logic                  rsp_ready
);

    import mesh_geometry_pkg::*;
    import route_pkg::*;

    port_e        lk_port;      // xy choice at the next router
    dstport_enc_t lk_enc;
    logic         take;

    route_rsp_t   rsp_q;
    logic         rsp_valid_q;

    // xy order, x first then y
    always_comb begin
        if (mid.dest.x > mid.next_addr.x) begin
            lk_port = PORT_EAST;
        end else if (mid.dest.x < mid.next_addr.x) begin
            lk_port = PORT_WEST;
        end else if (mid.dest.y < mid.next_addr.y) begin
            lk_port = PORT_NORTH;  // smaller y lies north
        end else if (mid.dest.y > mid.next_addr.y) begin
            lk_port = PORT_SOUTH;
        end else begin
            lk_port = PORT_LOCAL;
        end
    end

    // back to the four bit form, unused direction bit kept 0
    always_comb begin
        lk_enc.x    = 1'b0;
        lk_enc.y    = 1'b0;
        lk_enc.move = MOVE_LOCAL;
        case (lk_port)
            PORT_EAST: begin
                lk_enc.x    = 1'b1;
                lk_enc.move = MOVE_X;
            end
            PORT_WEST: begin
                lk_enc.move = MOVE_X;
            end
            PORT_NORTH: begin
                lk_enc.y    = 1'b1;
                lk_enc.move = MOVE_Y;
            end
            PORT_SOUTH: begin
                lk_enc.move = MOVE_Y;
            end
            default: begin
                lk_enc.move = MOVE_LOCAL;
            end
        endcase
    end

    assign mid_ready = !rsp_valid_q || rsp_ready;
    assign take      = mid_valid && mid_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q <= 1'b0;
        end else if (mid_ready) begin
            rsp_valid_q <= mid_valid;
        end
    end

    // payload held while the consumer stalls
    always_ff @(posedge clk) begin
        if (take) begin
            rsp_q.dest      <= mid.dest;
            rsp_q.next_addr <= mid.next_addr;
            rsp_q.lk_port   <= lk_enc;
        end
    end

    assign rsp       = rsp_q;
    assign rsp_valid = rsp_valid_q;

endmodule

`default_nettype wire

//--- verification/lookahead_route_chk.sv
`timescale 1ns/100ps
`default_nettype none

module lookahead_route_chk (
    input logic                  clk,
    input logic                  arst_n,
    input route_pkg::route_rsp_t rsp,
    input logic                  rsp_valid,
    input logic                  rsp_ready
);

    import route_pkg::*;

    int fail_count = 0;

    // async reset clears the response register
    rsp_low_in_reset: assert property (@(posedge clk) !arst_n |-> !rsp_valid)
        else begin
            $error("rsp_valid high while arst_n is low");
            fail_count++;
        end

    // stalled response keeps valid and payload
    rsp_held_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            $error("rsp changed or dropped while rsp_ready low");
            fail_count++;
        end

    // xy routing never asks for both axes
    no_both_move: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> rsp.lk_port.move != MOVE_XY)
        else begin
            $error("rsp carries move class 11");
            fail_count++;
        end

    rsp_known: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> !$isunknown(rsp))
        else begin
            $error("rsp has unknown bits while valid");
            fail_count++;
        end

endmodule

bind lookahead_route_top lookahead_route_chk chk_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
);

`default_nettype wire

//--- verification/lookahead_route_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lookahead_settings.svh"

module lookahead_route_tb;

    import mesh_geometry_pkg::*;
    import route_pkg::*;

    localparam coord_x_t ROUTER_X = 2'd1;
    localparam coord_y_t ROUTER_Y = 2'd2;
    localparam int       TIMEOUT  = 100;  // edges per wait
    localparam int       SWEEP_N  = 40;

    logic       clk = 1'b0;
    logic       arst_n;
    route_req_t req;
    logic       req_valid;
    logic       req_ready;
    route_rsp_t rsp;
    logic       rsp_valid;
    logic       rsp_ready;

    route_rsp_t exp_q[$];    // expected responses, request order
    int         rsp_cyc[$];  // cycle of each response transfer
    route_rsp_t exp_rsp;
    int         cyc = 0;
    int         rcv_count = 0;
    int         err_count = 0;
    int         err_start = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         seed = 76;
    string      test_name = "none";

    lookahead_route_top #(
        .ROUTER_X  (ROUTER_X),
        .ROUTER_Y  (ROUTER_Y)
    ) dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // xy choice at router (ax, ay) toward (dx, dy), four bit form
    function automatic dstport_enc_t xy_encode(input int ax, input int ay,
                                               input int dx, input int dy);
        dstport_enc_t p;
        p = '{1'b0, 1'b0, MOVE_LOCAL};
        if (dx != ax) begin
            p.move = MOVE_X;
            p.x    = (dx > ax);
        end else if (dy != ay) begin
            p.move = MOVE_Y;
            p.y    = (dy < ay);  // north is toward smaller y
        end
        return p;
    endfunction

    function automatic route_req_t make_req(input int dx, input int dy, input dstport_enc_t p);
        route_req_t r;
        r.dest.x   = coord_x_t'(dx);
        r.dest.y   = coord_y_t'(dy);
        r.cur_port = p;
        return r;
    endfunction

    function automatic route_req_t req_toward(input int dx, input int dy);
        return make_req(dx, dy, xy_encode(ROUTER_X, ROUTER_Y, dx, dy));
    endfunction

    task automatic predict_rsp(input route_req_t r, output route_rsp_t e);
        int nx;
        int ny;
        nx = ROUTER_X;
        ny = ROUTER_Y;
        if (r.cur_port.move == MOVE_Y)
            ny = r.cur_port.y ? ny - 1 : ny + 1;
        else if (r.cur_port.move != MOVE_LOCAL)
            nx = r.cur_port.x ? nx + 1 : nx - 1;  // 11 counts as an x-move
        // a hop off the mesh edge stays put
        nx = (nx < 0) ? 0 : (nx > `LKR_NX - 1) ? `LKR_NX - 1 : nx;
        ny = (ny < 0) ? 0 : (ny > `LKR_NY - 1) ? `LKR_NY - 1 : ny;
        e.dest        = r.dest;
        e.next_addr.x = coord_x_t'(nx);
        e.next_addr.y = coord_y_t'(ny);
        e.lk_port     = xy_encode(nx, ny, r.dest.x, r.dest.y);
    endtask

    task automatic check_addr(input string what, input router_addr_t exp,
                              input router_addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_port(input string what, input dstport_enc_t exp,
                              input dstport_enc_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        err_count++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = err_count;
    endtask

    task automatic end_test();
        if (err_count == err_start) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, err_count - err_start);
        end
    endtask

    // hold the request until accepted or limit edges pass
    task automatic offer(input route_req_t r, input int limit, output bit ok);
        route_rsp_t e;
        int         t;
        req       <= r;
        req_valid <= 1'b1;
        ok = 1'b0;
        t  = 0;
        while (!ok && t < limit) begin
            @(posedge clk);
            t++;
            ok = (req_ready === 1'b1);
        end
        if (ok) begin
            predict_rsp(r, e);
            exp_q.push_back(e);
        end
    endtask

    task automatic send(input route_req_t r);
        bit ok;
        offer(r, TIMEOUT, ok);
        if (!ok)
            report_timeout("req_ready");
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (exp_q.size() != 0)
            report_timeout("outstanding responses");
    endtask

    // response side, compares each transfer in order
    always @(posedge clk) begin
        if (arst_n && rsp_valid && rsp_ready) begin
            rcv_count++;
            rsp_cyc.push_back(cyc);
            if (exp_q.size() == 0) begin
                $display("%s: response arrived with no request outstanding", test_name);
                err_count++;
            end else begin
                exp_rsp = exp_q.pop_front();
                check_addr("dest", exp_rsp.dest, rsp.dest);
                check_addr("next_addr", exp_rsp.next_addr, rsp.next_addr);
                check_port("lk_port", exp_rsp.lk_port, rsp.lk_port);
            end
        end
    end

    task automatic reset_state();
        int k;
        start_test("reset_state");
        arst_n <= 1'b0;
        for (k = 0; k < 16; k++) begin
            @(posedge clk);
            check_flag("rsp_valid in reset", 1'b0, rsp_valid);
            check_flag("req_ready in reset", 1'b1, req_ready);
        end
        arst_n <= 1'b1;
        for (k = 0; k < 3; k++) begin
            @(posedge clk);
            check_flag("rsp_valid after reset", 1'b0, rsp_valid);
            check_flag("req_ready after reset", 1'b1, req_ready);
        end
        end_test();
    endtask

    task automatic each_direction();
        route_req_t r[5];
        int         k;
        int         lat;
        start_test("each_direction");
        r[0] = make_req(1, 2, '{1'b0, 1'b0, MOVE_LOCAL}); // stays here, local
        r[1] = make_req(3, 0, '{1'b1, 1'b0, MOVE_X});     // east, then east
        r[2] = make_req(1, 0, '{1'b0, 1'b1, MOVE_Y});     // north, then north
        r[3] = make_req(0, 3, '{1'b0, 1'b0, MOVE_X});     // west, then south
        r[4] = make_req(0, 3, '{1'b0, 1'b0, MOVE_Y});     // south, then west
        for (k = 0; k < 5; k++) begin
            send(r[k]);
            req_valid <= 1'b0;
            lat = 0;
            do begin
                @(posedge clk);
                lat++;
            end while (rsp_valid !== 1'b1 && lat < TIMEOUT);
            if (lat != 2) begin
                $display("CHECK FAILED %s latency: expected 2 actual %0d", test_name, lat);
                err_count++;
            end
            wait_drain();
        end
        end_test();
    endtask

    task automatic streaming();
        int k;
        start_test("streaming");
        rsp_cyc.delete();
        for (k = 0; k < 20; k++)
            send(req_toward(k % 4, (k / 4) % 4));
        req_valid <= 1'b0;
        wait_drain();
        if (rsp_cyc.size() != 20) begin
            $display("CHECK FAILED %s responses: expected 20 actual %0d",
                     test_name, rsp_cyc.size());
            err_count++;
        end else if (rsp_cyc[19] - rsp_cyc[0] != 19) begin
            $display("CHECK FAILED %s response span: expected 19 actual %0d",
                     test_name, rsp_cyc[19] - rsp_cyc[0]);
            err_count++;
        end
        end_test();
    endtask

    task automatic back_pressure();
        route_req_t r;
        route_rsp_t held;
        int         accepted;
        int         k;
        bit         ok;
        start_test("back_pressure");
        rsp_ready <= 1'b0;
        accepted = 0;
        ok = 1'b1;
        for (k = 0; k < 4 && ok; k++) begin
            r = req_toward(3 - k, k);
            offer(r, 4, ok);
            if (ok)
                accepted++;
        end
        if (accepted > 2) begin
            $display("CHECK FAILED %s accepted while stalled: expected at most 2 actual %0d",
                     test_name, accepted);
            err_count++;
        end
        check_flag("req_ready while stalled", 1'b0, req_ready);
        check_flag("rsp_valid while stalled", 1'b1, rsp_valid);
        held = rsp;
        repeat (3) @(posedge clk);
        check_addr("held next_addr", held.next_addr, rsp.next_addr);
        check_port("held lk_port", held.lk_port, rsp.lk_port);
        rsp_ready <= 1'b1;
        if (!ok) begin
            offer(r, TIMEOUT, ok);  // stalled request goes through now
            if (!ok)
                report_timeout("req_ready after release");
        end
        req_valid <= 1'b0;
        wait_drain();
        end_test();
    endtask

    task automatic random_sweep();
        route_req_t r[SWEEP_N];
        int         gap[SWEEP_N];
        bit         rdy[256];
        int         k;
        int         t;
        int         dx;
        int         dy;
        int         rcv_start;
        start_test("random_sweep");
        for (k = 0; k < SWEEP_N; k++) begin
            dx     = $unsigned($random(seed)) % `LKR_NX;
            dy     = $unsigned($random(seed)) % `LKR_NY;
            r[k]   = req_toward(dx, dy);
            gap[k] = $unsigned($random(seed)) % 3;
        end
        for (k = 0; k < 256; k++)
            rdy[k] = ($random(seed) % 4) != 0;  // ready about three cycles in four
        rcv_start = rcv_count;
        fork
            begin
                for (k = 0; k < SWEEP_N; k++) begin
                    req_valid <= 1'b0;
                    repeat (gap[k]) @(posedge clk);
                    send(r[k]);
                end
                req_valid <= 1'b0;
            end
            begin
                t = 0;
                while (rcv_count - rcv_start < SWEEP_N && t < 10 * TIMEOUT) begin
                    @(posedge clk);
                    rsp_ready <= rdy[t % 256];
                    t++;
                end
                if (rcv_count - rcv_start < SWEEP_N)
                    report_timeout("sweep responses");
            end
        join
        rsp_ready <= 1'b1;
        wait_drain();
        end_test();
    endtask

    task automatic illegal_move_class();
        start_test("illegal_move_class");
        send(make_req(3, 0, '{1'b1, 1'b0, MOVE_XY}));  // east to (2,2)
        send(make_req(3, 0, '{1'b0, 1'b1, MOVE_XY}));  // west to (0,2), y bit ignored
        req_valid <= 1'b0;
        wait_drain();
        end_test();
    endtask

    initial begin
        arst_n    <= 1'b0;
        req       <= '0;
        req_valid <= 1'b0;
        rsp_ready <= 1'b1;
        reset_state();
        each_direction();
        streaming();
        back_pressure();
        random_sweep();
        illegal_move_class();
        @(posedge clk);
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, dut_i.chk_i.fail_count);
        if (tests_failed == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
